//--- hdl/usb_ahb_pkg.sv
package usb_ahb_pkg;

  // ********************
  // Widths
  // ********************

  // One buffer byte and one AHB data word
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;

  // Register address and AHB size code
  typedef logic [3:0]  haddr_t;
  typedef logic [1:0]  hsize_t;

  // FIFO fill count 0..64 and push byte count 0..4
  typedef logic [6:0]  occupancy_t;
  typedef logic [2:0]  lane_count_t;

  // FIFO geometry
  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int BUS_LANES  = $bits(word_t) / $bits(byte_t);
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  // ********************
  // Address map
  // ********************
  localparam haddr_t ADDR_DATA_BUFFER = 4'd0;
  localparam haddr_t ADDR_STATUS_BUSY = 4'd4;
  localparam haddr_t ADDR_STATUS_ERR  = 4'd6;
  localparam haddr_t ADDR_BUFFER_SIZE = 4'd8;
  localparam haddr_t ADDR_TX_PACKET   = 4'd12;
  localparam haddr_t ADDR_FLUSH_CTRL  = 4'd13;

  // AHB transfer and size codes
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam hsize_t     HSIZE_BYTE    = 2'd0;
  localparam hsize_t     HSIZE_HALF    = 2'd1;
  localparam hsize_t     HSIZE_WORD    = 2'd2;

  // ********************
  // Enums and structs
  // ********************
  typedef enum logic [1:0] {PKT_NONE, PKT_DATA, PKT_ACK, PKT_NAK} packet_code_t;
  typedef enum logic [1:0] {SND_IDLE, SND_HANDSHAKE, SND_DATA} sender_state_t;

  // Address phase of one AHB transfer
  typedef struct packed {
    logic       hsel;
    logic [1:0] htrans;
    haddr_t     haddr;
    hsize_t     hsize;
    logic       hwrite;
  } ahb_req_t;

  // Push of up to four bytes, lowest lane first
  typedef struct packed {
    word_t       data;
    lane_count_t count;
  } fifo_push_t;

  // Packet start request
  typedef struct packed {
    logic         start;
    packet_code_t packet;
  } tx_cmd_t;

endpackage

//--- hdl/ahb_slave_regs.sv
`timescale 1ns/10ps

module ahb_slave_regs
  import usb_ahb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  ahb_req_t   ahb_req,
  input  word_t      hwdata,
  output word_t      hrdata,
  output logic       hready,
  output logic       hresp,
  input  occupancy_t occupancy,
  input  logic       busy,
  output logic       push,
  output fifo_push_t push_data,
  output logic       flush,
  output tx_cmd_t    tx_cmd
);

  // Registered address phase
  ahb_req_t     dp_req;
  logic         dp_valid;
  // Second cycle of the error response
  logic         err_second;

  // Decode of the data phase
  lane_count_t  lane_count;
  logic         aligned;
  logic         in_data;
  logic         in_status;
  logic         in_size;
  logic         in_ctrl;
  logic         ctrl_ok;
  logic         wr_tx;
  logic         wr_flush;
  logic         start_req;
  logic         fits;
  logic         legal;
  logic         error_now;
  logic         accept;
  logic         overflow_err;
  packet_code_t wr_code;
  word_t        rdata;

  // Register file
  logic         overflow_flag;
  packet_code_t last_code;

  // ********************
  // Address phase capture
  // ********************

  // New address phase is dropped during the first error cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dp_valid   <= 1'b0;
      dp_req     <= '0;
      err_second <= 1'b0;
    end
    else
    begin
      err_second <= error_now;
      if (hready)
      begin
        dp_valid <= ahb_req.hsel &&
                    (ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ);
        dp_req   <= ahb_req;
      end
      else
      begin
        dp_valid <= 1'b0;
      end
    end
  end

  // ********************
  // Decode
  // ********************
  always_comb
  begin
    // Bytes moved by one transfer, size 3 is never legal
    case (dp_req.hsize)
      HSIZE_BYTE: lane_count = 3'd1;
      HSIZE_HALF: lane_count = 3'd2;
      HSIZE_WORD: lane_count = 3'd4;
      default:    lane_count = 3'd0;
    endcase

    case (dp_req.hsize)
      HSIZE_BYTE: aligned = 1'b1;
      HSIZE_HALF: aligned = ~dp_req.haddr[0];
      HSIZE_WORD: aligned = (dp_req.haddr[1:0] == 2'b00);
      default:    aligned = 1'b0;
    endcase
  end

  // Word regions of the map
  assign in_data   = (dp_req.haddr[3:2] == ADDR_DATA_BUFFER[3:2]);
  assign in_status = (dp_req.haddr[3:2] == ADDR_STATUS_BUSY[3:2]);
  assign in_size   = (dp_req.haddr[3:2] == ADDR_BUFFER_SIZE[3:2]);
  assign in_ctrl   = (dp_req.haddr[3:2] == ADDR_TX_PACKET[3:2]);

  // Control word only has bytes 12 and 13, 14 and 15 are unused
  assign ctrl_ok   = in_ctrl && !dp_req.haddr[1] && (dp_req.hsize != HSIZE_WORD);

  // Lanes touched inside the control word
  assign wr_tx     = ctrl_ok && (dp_req.haddr == ADDR_TX_PACKET);
  assign wr_flush  = ctrl_ok && ((dp_req.haddr == ADDR_FLUSH_CTRL) ||
                     (dp_req.haddr == ADDR_TX_PACKET && dp_req.hsize == HSIZE_HALF));
  assign wr_code   = packet_code_t'(hwdata[8*ADDR_TX_PACKET[1:0] +: 2]);
  assign start_req = wr_tx && (wr_code != PKT_NONE);

  // Room check against the current fill level
  assign fits = (occupancy + occupancy_t'(lane_count)) <= occupancy_t'(FIFO_DEPTH);

  always_comb
  begin
    if (!aligned)
      legal = 1'b0;
    else if (dp_req.hwrite)
      legal = (in_data && fits) || (ctrl_ok && !(start_req && busy));
    else
      legal = in_status || in_size || ctrl_ok;
  end

  assign error_now    = dp_valid && !legal;
  assign accept       = dp_valid && legal && dp_req.hwrite;
  assign overflow_err = dp_valid && dp_req.hwrite && aligned && in_data && !fits;

  // ********************
  // Bus response
  // ********************

  // First error cycle stalls, second one completes
  assign hready = ~error_now;
  assign hresp  = error_now | err_second;

  // Each field sits in the byte lane of its address
  always_comb
  begin
    rdata = '0;
    if (in_status)
    begin
      rdata[8*ADDR_STATUS_BUSY[1:0]] = busy;
      rdata[8*ADDR_STATUS_ERR[1:0]]  = overflow_flag;
    end
    else if (in_size)
    begin
      rdata[8*ADDR_BUFFER_SIZE[1:0] +: $bits(occupancy_t)] = occupancy;
    end
    else if (in_ctrl)
    begin
      rdata[8*ADDR_TX_PACKET[1:0] +: $bits(packet_code_t)] = last_code;
    end
  end

  assign hrdata = rdata;

  // ********************
  // Side effects
  // ********************

  // Shift the addressed lane down to lane 0
  assign push            = accept && in_data;
  assign push_data.data  = hwdata >> (8 * dp_req.haddr[1:0]);
  assign push_data.count = lane_count;

  assign flush         = accept && wr_flush && hwdata[8*ADDR_FLUSH_CTRL[1:0]];
  assign tx_cmd.start  = accept && start_req;
  assign tx_cmd.packet = wr_code;

  // Sticky overflow flag and last started packet
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      overflow_flag <= 1'b0;
      last_code     <= PKT_NONE;
    end
    else
    begin
      if (flush)
        overflow_flag <= 1'b0;
      else if (overflow_err)
        overflow_flag <= 1'b1;
      if (tx_cmd.start)
        last_code <= wr_code;
    end
  end

endmodule

//--- hdl/tx_fifo.sv
`timescale 1ns/10ps

module tx_fifo
  import usb_ahb_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  fifo_push_t push_data,
  input  logic       flush,
  input  logic       pop,
  output byte_t      head,
  output logic       empty,
  output occupancy_t occupancy
);

  // Circular byte store
  byte_t      mem [FIFO_DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;
  occupancy_t fill;
  occupancy_t push_bytes;
  occupancy_t pop_bytes;

  // ********************
  // Storage
  // ********************

  // Lane i lands i slots past the write pointer
  always_ff @(posedge clk)
  begin
    if (push && !flush)
    begin
      for (int i = 0; i < BUS_LANES; i++)
      begin
        if (lane_count_t'(i) < push_data.count)
          mem[wr_ptr + fifo_ptr_t'(i)] <= push_data.data[8*i +: 8];
      end
    end
  end

  // ********************
  // Pointers and fill
  // ********************
  assign push_bytes = push ? occupancy_t'(push_data.count) : '0;
  assign pop_bytes  = occupancy_t'(pop);

  // Flush wins over push and pop
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + fifo_ptr_t'(push_data.count);
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      fill <= fill + push_bytes - pop_bytes;
    end
  end

  // Head is visible without a read strobe
  assign head      = mem[rd_ptr];
  assign empty     = (fill == '0);
  assign occupancy = fill;

endmodule

//--- hdl/tx_packet_sender.sv
`timescale 1ns/10ps

module tx_packet_sender
  import usb_ahb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  tx_cmd_t      tx_cmd,
  input  byte_t        head,
  input  logic         empty,
  output logic         pop,
  output logic         busy,
  input  logic         tx_byte_req,
  output logic         tx_en,
  output packet_code_t tx_packet,
  output byte_t        tx_data,
  output logic         tx_byte_strobe
);

  sender_state_t state;
  packet_code_t  packet;

  // Busy for the whole packet
  assign busy      = (state != SND_IDLE);
  assign tx_en     = busy;
  assign tx_packet = packet;

  // Byte request with data waiting pops the head at once
  assign pop = (state == SND_DATA) && tx_byte_req && !empty;

  // ********************
  // Packet FSM
  // ********************
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state          <= SND_IDLE;
      packet         <= PKT_NONE;
      tx_byte_strobe <= 1'b0;
    end
    else
    begin
      tx_byte_strobe <= pop;
      case (state)
        SND_IDLE:
        begin
          if (tx_cmd.start && tx_cmd.packet != PKT_NONE)
          begin
            packet <= tx_cmd.packet;
            if (tx_cmd.packet == PKT_DATA)
              state <= SND_DATA;
            else
              state <= SND_HANDSHAKE;
          end
        end
        // ACK or NAK, one cycle only
        SND_HANDSHAKE:
        begin
          state  <= SND_IDLE;
          packet <= PKT_NONE;
        end
        // Request on an empty buffer ends the packet
        SND_DATA:
        begin
          if (tx_byte_req && empty)
          begin
            state  <= SND_IDLE;
            packet <= PKT_NONE;
          end
        end
        default:
        begin
          state  <= SND_IDLE;
          packet <= PKT_NONE;
        end
      endcase
    end
  end

  // Byte goes out with the strobe one cycle after its request
  always_ff @(posedge clk)
  begin
    if (pop)
      tx_data <= head;
  end

endmodule

//--- hdl/usb_ahb_endpoint.sv
`timescale 1ns/10ps

module usb_ahb_endpoint
  import usb_ahb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  ahb_req_t     ahb_req,
  input  word_t        hwdata,
  output word_t        hrdata,
  output logic         hready,
  output logic         hresp,
  input  logic         tx_byte_req,
  output logic         tx_en,
  output packet_code_t tx_packet,
  output byte_t        tx_data,
  output logic         tx_byte_strobe
);

  // Register block to FIFO
  logic       push;
  fifo_push_t push_data;
  logic       flush;
  occupancy_t occupancy;

  // Register block to sender
  tx_cmd_t    tx_cmd;
  logic       busy;

  // Sender to FIFO
  logic       pop;
  byte_t      head;
  logic       empty;

  // ********************
  // Blocks
  // ********************
  ahb_slave_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .ahb_req   (ahb_req),
    .hwdata    (hwdata),
    .hrdata    (hrdata),
    .hready    (hready),
    .hresp     (hresp),
    .occupancy (occupancy),
    .busy      (busy),
    .push      (push),
    .push_data (push_data),
    .flush     (flush),
    .tx_cmd    (tx_cmd)
  );

  tx_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .flush     (flush),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .occupancy (occupancy)
  );

  tx_packet_sender u_sender (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx_cmd         (tx_cmd),
    .head           (head),
    .empty          (empty),
    .pop            (pop),
    .busy           (busy),
    .tx_byte_req    (tx_byte_req),
    .tx_en          (tx_en),
    .tx_packet      (tx_packet),
    .tx_data        (tx_data),
    .tx_byte_strobe (tx_byte_strobe)
  );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
  output logic clk
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD = 50;

  initial
  begin
    clk = 1'b0;
    forever
      #HALF_PERIOD clk = ~clk;
  end

endmodule

//--- verif/tb_usb_ahb_endpoint.sv
`timescale 1ns/10ps

module tb_usb_ahb_endpoint
  import usb_ahb_pkg::*;
();

  localparam logic [31:0] LCG_SEED = 32'hb89e_d39c;
  localparam int NUM_RAND_WRITES = 40;
  localparam int NUM_REFILL      = 12;
  localparam int NUM_HANDSHAKE   = 4;
  // Upper bound on transfers and byte requests
  localparam int TXN_COUNT = 2 * NUM_RAND_WRITES + 3 * FIFO_DEPTH + NUM_REFILL
                             + 3 * NUM_HANDSHAKE + 32;

  logic         tb_clk;
  logic         rst_n;
  ahb_req_t     ahb_req;
  word_t        hwdata;
  word_t        hrdata;
  logic         hready;
  logic         hresp;
  logic         tx_byte_req;
  logic         tx_en;
  packet_code_t tx_packet;
  byte_t        tx_data;
  logic         tx_byte_strobe;

  // Reference model state
  byte_t        model_q[$];
  logic         model_err;
  logic         model_busy;
  packet_code_t model_code;

  logic [31:0]  lcg_state;

  tb_clock_gen u_clk (.clk(tb_clk));

  usb_ahb_endpoint uut (
    .clk            (tb_clk),
    .rst_n          (rst_n),
    .ahb_req        (ahb_req),
    .hwdata         (hwdata),
    .hrdata         (hrdata),
    .hready         (hready),
    .hresp          (hresp),
    .tx_byte_req    (tx_byte_req),
    .tx_en          (tx_en),
    .tx_packet      (tx_packet),
    .tx_data        (tx_data),
    .tx_byte_strobe (tx_byte_strobe)
  );

  // ********************
  // Reporting and helpers
  // ********************
  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    stop_with_failure();
  endtask

  task automatic report_error(input string text);
    $display("ERROR: %s at %0t", text, $time);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp)
    else report_mismatch(name, got, exp);
  endtask

  // Numerical Recipes constants, full 32-bit state
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Busy is bit 0 of byte 4, flag is bit 0 of byte 6 (lane 2)
  function automatic word_t status_word();
    word_t w;
    w = '0;
    w[0]  = model_busy;
    w[16] = model_err;
    return w;
  endfunction

  task automatic idle_bus();
    ahb_req = '0;
  endtask

  // ********************
  // AHB transfer
  // ********************

  // One single transfer, outputs sampled mid data phase
  task automatic ahb_xfer(input haddr_t addr, input hsize_t size, input logic write,
                          input word_t wdata, input logic exp_err, input logic chk_rd,
                          input word_t exp_rd);
    @(negedge tb_clk);
    ahb_req.hsel   = 1'b1;
    ahb_req.htrans = HTRANS_NONSEQ;
    ahb_req.haddr  = addr;
    ahb_req.hsize  = size;
    ahb_req.hwrite = write;
    hwdata         = wdata;
    @(negedge tb_clk);
    if (exp_err)
    begin
      // Stall cycle, then completing cycle
      check_value("hready", word_t'(hready), 32'h0);
      check_value("hresp", word_t'(hresp), 32'h1);
      idle_bus();
      @(negedge tb_clk);
      check_value("hready", word_t'(hready), 32'h1);
      check_value("hresp", word_t'(hresp), 32'h1);
    end
    else
    begin
      check_value("hready", word_t'(hready), 32'h1);
      check_value("hresp", word_t'(hresp), 32'h0);
      if (chk_rd)
        check_value("hrdata", hrdata, exp_rd);
      idle_bus();
    end
  endtask

  task automatic read_expect(input haddr_t addr, input hsize_t size, input word_t exp);
    ahb_xfer(addr, size, 1'b0, '0, 1'b0, 1'b1, exp);
  endtask

  // Size, status and packet code against the model
  task automatic check_model_regs();
    read_expect(ADDR_BUFFER_SIZE, HSIZE_WORD, word_t'(model_q.size()));
    read_expect(ADDR_STATUS_BUSY, HSIZE_WORD, status_word());
    read_expect(ADDR_TX_PACKET, HSIZE_BYTE, word_t'(model_code));
  endtask

  // Random legal size and offset in the data buffer window
  task automatic rand_data_write();
    logic [31:0] r;
    hsize_t      size;
    logic [1:0]  off;
    int          count;
    word_t       wdata;
    logic        fits;
    r     = lcg_next();
    wdata = lcg_next();
    size  = hsize_t'(r[31:16] % 3);
    case (size)
      HSIZE_BYTE: off = r[25:24];
      HSIZE_HALF: off = {r[25], 1'b0};
      default:    off = 2'd0;
    endcase
    count = 1 << size;
    fits  = (model_q.size() + count) <= FIFO_DEPTH;
    // Lane of each byte follows its address
    if (fits)
    begin
      for (int i = 0; i < count; i++)
        model_q.push_back(wdata[8 * (off + i) +: 8]);
    end
    else
      model_err = 1'b1;
    ahb_xfer(haddr_t'(off), size, 1'b1, wdata, !fits, 1'b0, '0);
  endtask

  task automatic flush_buffer();
    ahb_xfer(ADDR_FLUSH_CTRL, HSIZE_BYTE, 1'b1, word_t'(1) << (8 * ADDR_FLUSH_CTRL[1:0]),
             1'b0, 1'b0, '0);
    model_q.delete();
    model_err = 1'b0;
  endtask

  // ********************
  // Packet tests
  // ********************

  // Random byte requests until one finds the buffer empty
  task automatic run_data_packet();
    int          remaining;
    logic        req_prev;
    logic        req_empty_prev;
    logic        done;
    logic [31:0] r;
    byte_t       exp_byte;
    remaining      = model_q.size();
    req_prev       = 1'b0;
    req_empty_prev = 1'b0;
    done           = 1'b0;
    while (!done)
    begin
      @(negedge tb_clk);
      check_value("tx_byte_strobe", word_t'(tx_byte_strobe),
                  word_t'(req_prev && !req_empty_prev));
      if (tx_byte_strobe)
      begin
        exp_byte = model_q.pop_front();
        check_value("tx_data", word_t'(tx_data), word_t'(exp_byte));
      end
      if (req_empty_prev)
      begin
        check_value("tx_en", word_t'(tx_en), 32'h0);
        tx_byte_req = 1'b0;
        done        = 1'b1;
      end
      else
      begin
        check_value("tx_en", word_t'(tx_en), 32'h1);
        check_value("tx_packet", word_t'(tx_packet), word_t'(PKT_DATA));
        r              = lcg_next();
        tx_byte_req    = r[31];
        req_prev       = r[31];
        req_empty_prev = r[31] && (remaining == 0);
        if (r[31] && remaining > 0)
          remaining--;
      end
    end
    model_busy = 1'b0;
  endtask

  // ACK or NAK holds tx_en for one cycle
  task automatic run_handshake(input packet_code_t code);
    ahb_xfer(ADDR_TX_PACKET, HSIZE_BYTE, 1'b1, word_t'(code), 1'b0, 1'b0, '0);
    check_value("tx_en", word_t'(tx_en), 32'h0);
    @(negedge tb_clk);
    check_value("tx_en", word_t'(tx_en), 32'h1);
    check_value("tx_packet", word_t'(tx_packet), word_t'(code));
    @(negedge tb_clk);
    check_value("tx_en", word_t'(tx_en), 32'h0);
    check_value("tx_packet", word_t'(tx_packet), word_t'(PKT_NONE));
    model_code = code;
    check_model_regs();
  endtask

  // ********************
  // Main sequence
  // ********************
  initial
  begin
    lcg_state   = LCG_SEED;
    model_err   = 1'b0;
    model_busy  = 1'b0;
    model_code  = PKT_NONE;
    rst_n       = 1'b0;
    ahb_req     = '0;
    hwdata      = '0;
    tx_byte_req = 1'b0;
    repeat (4) @(posedge tb_clk);
    @(negedge tb_clk);
    rst_n = 1'b1;

    // Reset values
    check_value("tx_en", word_t'(tx_en), 32'h0);
    check_value("hresp", word_t'(hresp), 32'h0);
    check_value("hready", word_t'(hready), 32'h1);
    check_value("tx_byte_strobe", word_t'(tx_byte_strobe), 32'h0);
    read_expect(ADDR_STATUS_BUSY, HSIZE_WORD, '0);
    read_expect(ADDR_STATUS_ERR, HSIZE_HALF, '0);
    read_expect(ADDR_BUFFER_SIZE, HSIZE_WORD, '0);
    read_expect(ADDR_TX_PACKET, HSIZE_BYTE, '0);

    // Fill past the top so one write overflows
    for (int i = 0; i < NUM_RAND_WRITES; i++)
    begin
      rand_data_write();
      read_expect(ADDR_BUFFER_SIZE, HSIZE_WORD, word_t'(model_q.size()));
    end
    while (!model_err)
      rand_data_write();
    check_model_regs();

    // Flush clears fill and flag
    flush_buffer();
    check_model_regs();

    // Illegal accesses leave every register alone
    repeat (3) rand_data_write();
    ahb_xfer(ADDR_STATUS_BUSY, HSIZE_WORD, 1'b1, lcg_next(), 1'b1, 1'b0, '0);
    ahb_xfer(ADDR_STATUS_ERR, HSIZE_HALF, 1'b1, 32'hffff_ffff, 1'b1, 1'b0, '0);
    ahb_xfer(ADDR_BUFFER_SIZE, HSIZE_WORD, 1'b1, lcg_next(), 1'b1, 1'b0, '0);
    ahb_xfer(4'd1, HSIZE_HALF, 1'b1, lcg_next(), 1'b1, 1'b0, '0);
    ahb_xfer(4'd2, HSIZE_WORD, 1'b1, lcg_next(), 1'b1, 1'b0, '0);
    ahb_xfer(ADDR_DATA_BUFFER, 2'd3, 1'b1, lcg_next(), 1'b1, 1'b0, '0);
    ahb_xfer(ADDR_FLUSH_CTRL, HSIZE_HALF, 1'b1, 32'hffff_ffff, 1'b1, 1'b0, '0);
    ahb_xfer(4'd14, HSIZE_BYTE, 1'b1, 32'hffff_ffff, 1'b1, 1'b0, '0);
    ahb_xfer(4'd15, HSIZE_BYTE, 1'b0, '0, 1'b1, 1'b0, '0);
    ahb_xfer(ADDR_DATA_BUFFER, HSIZE_WORD, 1'b0, '0, 1'b1, 1'b0, '0);
    check_value("tx_en", word_t'(tx_en), 32'h0);
    check_model_regs();

    // DATA packet, second start while busy is refused
    repeat (NUM_REFILL) rand_data_write();
    ahb_xfer(ADDR_TX_PACKET, HSIZE_BYTE, 1'b1, word_t'(PKT_DATA), 1'b0, 1'b0, '0);
    check_value("tx_en", word_t'(tx_en), 32'h0);
    model_busy = 1'b1;
    model_code = PKT_DATA;
    ahb_xfer(ADDR_TX_PACKET, HSIZE_BYTE, 1'b1, word_t'(PKT_NAK), 1'b1, 1'b0, '0);
    check_value("tx_en", word_t'(tx_en), 32'h1);
    check_model_regs();
    run_data_packet();
    check_model_regs();

    // ACK and NAK take turns
    for (int i = 0; i < NUM_HANDSHAKE; i++)
      run_handshake((i % 2 == 0) ? PKT_ACK : PKT_NAK);

    $display("TESTBENCH PASSED");
    $finish;
  end

  // ********************
  // Watchdog
  // ********************
  initial
  begin
    repeat (TXN_COUNT * 20) @(posedge tb_clk);
    report_error("Watchdog expired before the test sequence completed");
  end

endmodule

//--- usb_ahb_endpoint.f
hdl/usb_ahb_pkg.sv
hdl/ahb_slave_regs.sv
hdl/tx_fifo.sv
hdl/tx_packet_sender.sv
hdl/usb_ahb_endpoint.sv
verif/tb_clock_gen.sv
verif/tb_usb_ahb_endpoint.sv

//--- Bender.yml
package:
  name: usb_ahb_endpoint

sources:
  - files:
      - hdl/usb_ahb_pkg.sv
      - hdl/ahb_slave_regs.sv
      - hdl/tx_fifo.sv
      - hdl/tx_packet_sender.sv
      - hdl/usb_ahb_endpoint.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_usb_ahb_endpoint.sv
